/* cu_pkg.sv */
package cu_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int MEM_WAIT = 2;  // lw memory read steps
    localparam int EXC_WAIT = 2;  // Exception vector read steps
    localparam int WAIT_W   = 2;

    typedef enum logic [OPCODE_W-1:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        JAL    = 6'h03,
        BEQ    = 6'h04,
        BNE    = 6'h05,
        BLE    = 6'h06,
        BGT    = 6'h07,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        LUI    = 6'h0f,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FUNCT_JR  = 6'h08,
        FUNCT_ADD = 6'h20,
        FUNCT_SUB = 6'h22,
        FUNCT_AND = 6'h24
    } funct_e;

    typedef enum logic [3:0] {
        ALU_R, ALU_IMM, ALU_IMM_U, LUI_OP, LOAD, STORE,
        BRANCH, JUMP, JUMP_LINK, JUMP_REG, INVALID
    } instr_class_e;

    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LE, BR_GT} branch_cond_e;

    typedef enum logic [4:0] {
        ST_INIT_SP, ST_FETCH, ST_FETCH_COMMIT, ST_DECODE,
        ST_EXECUTE, ST_WRITEBACK_RD, ST_WRITEBACK_RT,
        ST_ADDR_CALC, ST_MEM_READ, ST_MDR_LOAD, ST_LOAD_WRITE, ST_STORE,
        ST_BRANCH_TAKEN, ST_BRANCH_NOT, ST_JUMP, ST_LINK_CALC, ST_LINK_WRITE,
        ST_JUMP_REG, ST_LUI_WRITE,
        ST_EXC_READ, ST_EXC_COMMIT
    } step_e;

    // Datapath select codes
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0, ALU_ADD = 3'd1, ALU_SUB = 3'd2, ALU_AND = 3'd3, ALU_CMP = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {SRCA_PC = 2'd0, SRCA_REG_A = 2'd1, SRCA_MDR = 2'd2} alu_src_a_e;

    typedef enum logic [2:0] {SRCB_REG_B = 3'd0, SRCB_FOUR = 3'd1, SRCB_IMM = 3'd2} alu_src_b_e;

    typedef enum logic [2:0] {
        IORD_PC = 3'd0, IORD_ALUOUT = 3'd1, IORD_EXC_VEC = 3'd2
    } iord_e;

    typedef enum logic [2:0] {
        PCSRC_ALU = 3'd0, PCSRC_BRANCH = 3'd1, PCSRC_JUMP = 3'd2, PCSRC_EXC = 3'd3
    } pc_src_e;

    typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_SP = 2'd2, DST_RA = 2'd3} reg_dst_e;

    typedef enum logic [3:0] {
        M2R_ALUOUT = 4'd0, M2R_MDR = 4'd1, M2R_SP_INIT = 4'd4, M2R_UPPER_IMM = 4'd8
    } mem_to_reg_e;

    typedef enum logic [1:0] {EXC_NO_OPCODE = 2'd0, EXC_OVERFLOW = 2'd1} except_e;

    typedef struct packed {
        step_e   step;
        alu_op_e alu_fn;
        except_e exc_cause;
    } step_word_t;

endpackage

/* decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import cu_pkg::*;

    logic         req;
    logic         ack;
    instr_class_e iclass;
    alu_op_e      alu_fn;
    branch_cond_e cond;

    modport decoder (
        output req, iclass, alu_fn, cond,
        input  ack
    );

    modport sequencer (
        input  req, iclass, alu_fn, cond,
        output ack
    );

endinterface

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        instr_req,
    input  logic                        instr_ack,
    input  logic [cu_pkg::OPCODE_W-1:0] opcode,
    input  logic [cu_pkg::FUNCT_W-1:0]  funct,
    decode_if.decoder                   dec
);
    import cu_pkg::*;

    logic [OPCODE_W-1:0] opcode_q;
    logic [FUNCT_W-1:0]  funct_q;

    // Memory handshake on one side, sequencer handshake on the other
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_req <= 1'b0;
            dec.req   <= 1'b0;
        end else if (instr_req) begin
            if (instr_ack) begin
                instr_req <= 1'b0;
                dec.req   <= 1'b1;
            end
        end else if (dec.req) begin
            if (dec.ack) begin
                dec.req <= 1'b0;
            end
        end else if (!dec.ack && !instr_ack) begin
            instr_req <= 1'b1;  // Previous instruction retired
        end
    end

    always_ff @(posedge clk) begin
        if (instr_req && instr_ack) begin
            opcode_q <= opcode;
            funct_q  <= funct;
        end
    end

    always_comb begin
        dec.iclass = INVALID;
        dec.alu_fn = ALU_ADD;
        dec.cond   = BR_EQ;
        case (opcode_e'(opcode_q))
            R_TYPE: begin
                case (funct_e'(funct_q))
                    FUNCT_ADD: dec.iclass = ALU_R;
                    FUNCT_SUB: begin
                        dec.iclass = ALU_R;
                        dec.alu_fn = ALU_SUB;
                    end
                    FUNCT_AND: begin
                        dec.iclass = ALU_R;
                        dec.alu_fn = ALU_AND;
                    end
                    FUNCT_JR: begin
                        dec.iclass = JUMP_REG;
                        dec.alu_fn = ALU_PASS;
                    end
                    default: dec.iclass = INVALID;
                endcase
            end
            ADDI:  dec.iclass = ALU_IMM;
            ADDIU: dec.iclass = ALU_IMM_U;
            LUI:   dec.iclass = LUI_OP;
            LW:    dec.iclass = LOAD;
            SW:    dec.iclass = STORE;
            BEQ, BNE, BLE, BGT: begin
                dec.iclass = BRANCH;
                dec.alu_fn = ALU_CMP;
                dec.cond   = branch_cond_e'(opcode_q[1:0]);  // Low opcode bits give EQ/NE/LE/GT
            end
            J:       dec.iclass = JUMP;
            JAL:     dec.iclass = JUMP_LINK;
            default: dec.iclass = INVALID;
        endcase
    end

endmodule

/* step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer (
    input  logic               clk,
    input  logic               reset,
    decode_if.sequencer        dec,
    input  logic               ov,
    input  logic               eq,
    input  logic               gt,
    output cu_pkg::step_word_t step_out
);
    import cu_pkg::*;

    step_e             step;
    logic [WAIT_W-1:0] wait_cnt;  // Shared by MEM_READ and EXC_READ
    except_e           exc_cause;
    logic              br_taken;

    always_comb begin
        case (dec.cond)
            BR_EQ:   br_taken = eq;
            BR_NE:   br_taken = !eq;
            BR_LE:   br_taken = !gt;
            default: br_taken = gt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step      <= ST_INIT_SP;
            wait_cnt  <= '0;
            exc_cause <= EXC_NO_OPCODE;
            dec.ack   <= 1'b0;
        end else begin
            case (step)
                ST_INIT_SP: step <= ST_FETCH;
                ST_FETCH: begin
                    if (dec.req) begin
                        step    <= ST_FETCH_COMMIT;
                        dec.ack <= 1'b1;  // Held until the instruction ends
                    end
                end
                ST_FETCH_COMMIT: step <= ST_DECODE;
                ST_DECODE: begin
                    case (dec.iclass)
                        ALU_R, ALU_IMM, ALU_IMM_U: step <= ST_EXECUTE;
                        LOAD, STORE: step <= ST_ADDR_CALC;
                        BRANCH:      step <= br_taken ? ST_BRANCH_TAKEN : ST_BRANCH_NOT;
                        JUMP:        step <= ST_JUMP;
                        JUMP_LINK:   step <= ST_LINK_CALC;
                        JUMP_REG:    step <= ST_JUMP_REG;
                        LUI_OP:      step <= ST_LUI_WRITE;
                        default: begin
                            step      <= ST_EXC_READ;
                            exc_cause <= EXC_NO_OPCODE;
                        end
                    endcase
                end
                ST_EXECUTE: begin
                    if (ov && dec.iclass != ALU_IMM_U) begin
                        step      <= ST_EXC_READ;
                        exc_cause <= EXC_OVERFLOW;
                    end else if (dec.iclass == ALU_R) begin
                        step <= ST_WRITEBACK_RD;
                    end else begin
                        step <= ST_WRITEBACK_RT;
                    end
                end
                ST_ADDR_CALC: step <= (dec.iclass == STORE) ? ST_STORE : ST_MEM_READ;
                ST_MEM_READ: begin
                    if (wait_cnt == WAIT_W'(MEM_WAIT - 1)) begin
                        step     <= ST_MDR_LOAD;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_MDR_LOAD:  step <= ST_LOAD_WRITE;
                ST_LINK_CALC: step <= ST_LINK_WRITE;
                ST_EXC_READ: begin
                    if (wait_cnt == WAIT_W'(EXC_WAIT - 1)) begin
                        step     <= ST_EXC_COMMIT;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: begin
                    // Last step of every instruction
                    step    <= ST_FETCH;
                    dec.ack <= 1'b0;
                end
            endcase
        end
    end

    assign step_out = '{step: step, alu_fn: dec.alu_fn, exc_cause: exc_cause};

endmodule

/* control_encoder.sv */
`timescale 1ns/1ps

module control_encoder (
    input  logic                clk,
    input  logic                reset,
    input  cu_pkg::step_word_t  step_in,
    output logic                pc_write,
    output logic                branch,
    output logic                mem_wr,
    output logic                ir_write,
    output logic                a_write,
    output logic                b_write,
    output logic                mdr_write,
    output logic                alu_reg_write,
    output logic                epc_write,
    output logic                reg_write,
    output cu_pkg::alu_op_e     alu_op,
    output cu_pkg::alu_src_a_e  alu_src_a,
    output cu_pkg::alu_src_b_e  alu_src_b,
    output cu_pkg::iord_e       iord,
    output cu_pkg::pc_src_e     pc_src,
    output cu_pkg::reg_dst_e    reg_dst,
    output cu_pkg::mem_to_reg_e mem_to_reg,
    output cu_pkg::except_e     except_cause
);
    import cu_pkg::*;

    always_ff @(posedge clk) begin
        // All zero unless the step asks otherwise
        pc_write      <= 1'b0;
        branch        <= 1'b0;
        mem_wr        <= 1'b0;
        ir_write      <= 1'b0;
        a_write       <= 1'b0;
        b_write       <= 1'b0;
        mdr_write     <= 1'b0;
        alu_reg_write <= 1'b0;
        epc_write     <= 1'b0;
        reg_write     <= 1'b0;
        alu_op        <= ALU_PASS;
        alu_src_a     <= SRCA_PC;
        alu_src_b     <= SRCB_REG_B;
        iord          <= IORD_PC;
        pc_src        <= PCSRC_ALU;
        reg_dst       <= DST_RT;
        mem_to_reg    <= M2R_ALUOUT;
        except_cause  <= EXC_NO_OPCODE;
        if (!reset) begin
            case (step_in.step)
                ST_INIT_SP: begin
                    reg_write  <= 1'b1;  // Stack top
                    reg_dst    <= DST_SP;
                    mem_to_reg <= M2R_SP_INIT;
                end
                ST_FETCH, ST_FETCH_COMMIT: begin
                    alu_src_b <= SRCB_FOUR;  // PC + 4
                    alu_op    <= ALU_ADD;
                    pc_write  <= (step_in.step == ST_FETCH_COMMIT);
                    ir_write  <= (step_in.step == ST_FETCH_COMMIT);
                end
                ST_DECODE: begin
                    a_write <= 1'b1;
                    b_write <= 1'b1;
                end
                ST_EXECUTE: begin
                    alu_src_a     <= SRCA_REG_A;
                    alu_op        <= step_in.alu_fn;
                    alu_reg_write <= 1'b1;
                end
                ST_WRITEBACK_RD, ST_WRITEBACK_RT: begin
                    reg_write <= 1'b1;
                    reg_dst   <= (step_in.step == ST_WRITEBACK_RD) ? DST_RD : DST_RT;
                end
                ST_ADDR_CALC: begin
                    alu_src_a     <= SRCA_REG_A;
                    alu_src_b     <= SRCB_IMM;
                    alu_op        <= ALU_ADD;
                    alu_reg_write <= 1'b1;
                end
                ST_MEM_READ: iord <= IORD_ALUOUT;
                ST_MDR_LOAD: begin
                    iord      <= IORD_ALUOUT;
                    mdr_write <= 1'b1;
                end
                ST_LOAD_WRITE: begin
                    reg_write  <= 1'b1;
                    mem_to_reg <= M2R_MDR;
                end
                ST_STORE: begin
                    iord   <= IORD_ALUOUT;
                    mem_wr <= 1'b1;
                end
                ST_BRANCH_TAKEN, ST_BRANCH_NOT: begin
                    alu_src_a <= SRCA_REG_A;  // Compare A with B
                    alu_op    <= ALU_CMP;
                    pc_src    <= PCSRC_BRANCH;
                    pc_write  <= (step_in.step == ST_BRANCH_TAKEN);
                end
                ST_JUMP: begin
                    pc_write <= 1'b1;
                    branch   <= 1'b1;
                    pc_src   <= PCSRC_JUMP;
                end
                ST_LINK_CALC: alu_reg_write <= 1'b1;  // Return address from PC
                ST_LINK_WRITE: begin
                    reg_write <= 1'b1;
                    reg_dst   <= DST_RA;
                    pc_write  <= 1'b1;
                    branch    <= 1'b1;
                    pc_src    <= PCSRC_JUMP;
                end
                ST_JUMP_REG: begin
                    alu_src_a <= SRCA_REG_A;
                    pc_write  <= 1'b1;
                    branch    <= 1'b1;
                end
                ST_LUI_WRITE: begin
                    reg_write  <= 1'b1;
                    mem_to_reg <= M2R_UPPER_IMM;
                end
                ST_EXC_READ: begin
                    iord         <= IORD_EXC_VEC;
                    except_cause <= step_in.exc_cause;
                    alu_src_b    <= SRCB_FOUR;  // EPC gets PC - 4
                    alu_op       <= ALU_SUB;
                end
                ST_EXC_COMMIT: begin
                    epc_write    <= 1'b1;
                    pc_write     <= 1'b1;
                    pc_src       <= PCSRC_EXC;
                    except_cause <= step_in.exc_cause;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                                   clk,
    input  logic                                   reset,
    output logic                                   instr_req,
    input  logic                                   instr_ack,
    input  logic [cu_pkg::OPCODE_W-1:0]            opcode,
    input  logic [cu_pkg::FUNCT_W-1:0]             funct,
    input  logic                                   ov,
    input  logic                                   eq,
    input  logic                                   gt,
    output logic                                   pc_write,
    output logic                                   branch,
    output logic                                   mem_wr,
    output logic                                   ir_write,
    output logic                                   a_write,
    output logic                                   b_write,
    output logic                                   mdr_write,
    output logic                                   alu_reg_write,
    output logic                                   epc_write,
    output logic                                   reg_write,
    output logic [$bits(cu_pkg::alu_op_e)-1:0]     alu_op,
    output logic [$bits(cu_pkg::alu_src_a_e)-1:0]  alu_src_a,
    output logic [$bits(cu_pkg::alu_src_b_e)-1:0]  alu_src_b,
    output logic [$bits(cu_pkg::iord_e)-1:0]       iord,
    output logic [$bits(cu_pkg::pc_src_e)-1:0]     pc_src,
    output logic [$bits(cu_pkg::reg_dst_e)-1:0]    reg_dst,
    output logic [$bits(cu_pkg::mem_to_reg_e)-1:0] mem_to_reg,
    output logic [$bits(cu_pkg::except_e)-1:0]     except_cause
);
    import cu_pkg::*;

    step_word_t step_word;

    decode_if dec_bus ();

    instr_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr_ack (instr_ack),
        .opcode    (opcode),
        .funct     (funct),
        .dec       (dec_bus.decoder)
    );

    step_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec_bus.sequencer),
        .ov       (ov),
        .eq       (eq),
        .gt       (gt),
        .step_out (step_word)
    );

    control_encoder u_encoder (
        .clk           (clk),
        .reset         (reset),
        .step_in       (step_word),
        .pc_write      (pc_write),
        .branch        (branch),
        .mem_wr        (mem_wr),
        .ir_write      (ir_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .mdr_write     (mdr_write),
        .alu_reg_write (alu_reg_write),
        .epc_write     (epc_write),
        .reg_write     (reg_write),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .iord          (iord),
        .pc_src        (pc_src),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .except_cause  (except_cause)
    );

endmodule

/* control_unit_asserts.sv */
`timescale 1ns/1ps

module control_unit_asserts (
    input logic clk,
    input logic reset,
    input logic instr_req,
    input logic instr_ack,
    input logic mem_wr,
    input logic reg_write,
    input logic pc_write,
    input logic epc_write
);

    // A new fetch waits for the previous ack to drop
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        (!instr_req && instr_ack) |=> !instr_req)
        else $error("instr_req raised while instr_ack was still high");

    req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        (instr_req && !instr_ack) |=> instr_req)
        else $error("instr_req dropped before instr_ack");

    no_store_and_write: assert property (@(posedge clk) disable iff (reset)
        !(mem_wr && reg_write))
        else $error("mem_wr and reg_write high in the same cycle");

    epc_with_pc: assert property (@(posedge clk) disable iff (reset)
        epc_write |-> pc_write)
        else $error("epc_write without pc_write");

endmodule

bind control_unit control_unit_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .mem_wr    (mem_wr),
    .reg_write (reg_write),
    .pc_write  (pc_write),
    .epc_write (epc_write)
);

/* tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit;
    import cu_pkg::*;

    localparam int FIELDS    = 12;  // Hex words per test line
    localparam int MAX_TESTS = 64;

    logic clk;
    logic reset;
    logic instr_req;
    logic instr_ack;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;
    logic ov;
    logic eq;
    logic gt;
    logic pc_write;
    logic branch;
    logic mem_wr;
    logic ir_write;
    logic a_write;
    logic b_write;
    logic mdr_write;
    logic alu_reg_write;
    logic epc_write;
    logic reg_write;
    logic [$bits(alu_op_e)-1:0]     alu_op;
    logic [$bits(alu_src_a_e)-1:0]  alu_src_a;
    logic [$bits(alu_src_b_e)-1:0]  alu_src_b;
    logic [$bits(iord_e)-1:0]       iord;
    logic [$bits(pc_src_e)-1:0]     pc_src;
    logic [$bits(reg_dst_e)-1:0]    reg_dst;
    logic [$bits(mem_to_reg_e)-1:0] mem_to_reg;
    logic [$bits(except_e)-1:0]     except_cause;

    logic [7:0] test_mem [0:FIELDS*MAX_TESTS-1];
    int    n_tests, test_idx, ack_delay, cycles, cycle_limit, errors, checks;
    int    rw_cnt, mw_cnt, pc_cnt, epc_cnt, other_cnt;
    int    last_reg_dst, last_m2r, last_pc_src;
    int    release_delay, exc_read_cnt, last_cause, last_mw_iord, last_alu_op;
    logic  started, done, req_prev;
    string test_tag;

    control_unit UUT (.*);

    always #2 clk = ~clk;

    function automatic int test_field(input int t, input int f);
        return int'(test_mem[t*FIELDS+f]);
    endfunction

    // ALU function due at EXECUTE or ADDR_CALC, -1 where none is due
    function automatic int alu_fn_for(input int t);
        case (test_field(t, 0))
            int'(R_TYPE): begin
                case (test_field(t, 1))
                    int'(FUNCT_ADD): return int'(ALU_ADD);
                    int'(FUNCT_SUB): return int'(ALU_SUB);
                    int'(FUNCT_AND): return int'(ALU_AND);
                    default:         return -1;
                endcase
            end
            int'(ADDI), int'(ADDIU), int'(LW), int'(SW): return int'(ALU_ADD);
            default: return -1;
        endcase
    endfunction

    task automatic compare(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0d ns: %s %s = %0d, expected %0d",
                     $time, test_tag, name, got, exp);
        end
    endtask

    task automatic expect_quiet_outputs();
        test_tag = "in reset";
        compare("instr_req", int'(instr_req), 0);
        compare("pc_write", int'(pc_write), 0);
        compare("branch", int'(branch), 0);
        compare("mem_wr", int'(mem_wr), 0);
        compare("ir_write", int'(ir_write), 0);
        compare("a_write", int'(a_write), 0);
        compare("b_write", int'(b_write), 0);
        compare("mdr_write", int'(mdr_write), 0);
        compare("alu_reg_write", int'(alu_reg_write), 0);
        compare("epc_write", int'(epc_write), 0);
        compare("reg_write", int'(reg_write), 0);
        compare("alu_op", int'(alu_op), 0);
        compare("alu_src_a", int'(alu_src_a), 0);
        compare("alu_src_b", int'(alu_src_b), 0);
        compare("iord", int'(iord), 0);
        compare("pc_src", int'(pc_src), 0);
        compare("reg_dst", int'(reg_dst), 0);
        compare("mem_to_reg", int'(mem_to_reg), 0);
        compare("except_cause", int'(except_cause), 0);
    endtask

    task automatic clear_counts();
        rw_cnt       = 0;
        mw_cnt       = 0;
        pc_cnt       = 0;
        epc_cnt      = 0;
        other_cnt    = 0;
        exc_read_cnt = 0;
        last_cause   = -1;
        last_mw_iord = -1;
        last_alu_op  = -1;
    endtask

    task automatic collect_pulses();
        if (reg_write) begin
            rw_cnt++;
            last_reg_dst = int'(reg_dst);
            last_m2r     = int'(mem_to_reg);
        end
        if (pc_write) begin
            pc_cnt++;
            last_pc_src = int'(pc_src);
        end
        if (mem_wr) begin
            mw_cnt++;
            last_mw_iord = int'(iord);
        end
        if (epc_write)
            epc_cnt++;
        if (alu_reg_write)
            last_alu_op = int'(alu_op);
        if (iord == IORD_EXC_VEC) begin
            exc_read_cnt++;  // Exception vector read
            last_cause = int'(except_cause);
        end
        if (ir_write || a_write || b_write || mdr_write || alu_reg_write || branch)
            other_cnt++;
    endtask

    task automatic check_reset();
        test_tag = "reset";
        compare("reg_write count", rw_cnt, 1);
        compare("reg_dst", last_reg_dst, int'(DST_SP));
        compare("mem_to_reg", last_m2r, int'(M2R_SP_INIT));
        compare("pc_write count", pc_cnt, 0);
        compare("mem_wr count", mw_cnt, 0);
        compare("epc_write count", epc_cnt, 0);
        compare("other strobe count", other_cnt, 0);
    endtask

    task automatic check_instruction(input int t);
        int exp_cause;
        test_tag = $sformatf("test %0d", t);
        // Overflow only traps a defined instruction
        exp_cause = (test_field(t, 2) != 0 && alu_fn_for(t) >= 0) ?
                    int'(EXC_OVERFLOW) : int'(EXC_NO_OPCODE);
        compare("reg_write count", rw_cnt, test_field(t, 5));
        compare("mem_wr count", mw_cnt, test_field(t, 6));
        compare("pc_write count", pc_cnt, test_field(t, 7));
        compare("epc_write count", epc_cnt, test_field(t, 8));
        if (test_field(t, 5) != 0) begin
            compare("reg_dst", last_reg_dst, test_field(t, 9));
            compare("mem_to_reg", last_m2r, test_field(t, 10));
        end
        compare("pc_src", last_pc_src, test_field(t, 11));
        compare("exception vector reads", exc_read_cnt, EXC_WAIT * test_field(t, 8));
        if (test_field(t, 8) != 0)
            compare("except_cause", last_cause, exp_cause);
        if (test_field(t, 6) != 0)
            compare("iord", last_mw_iord, int'(IORD_ALUOUT));
        if (alu_fn_for(t) >= 0)
            compare("alu_op", last_alu_op, alu_fn_for(t));
    endtask

    task automatic present_instruction(input int t);
        opcode        = test_mem[t*FIELDS][OPCODE_W-1:0];
        funct         = test_mem[t*FIELDS+1][FUNCT_W-1:0];
        ov            = test_mem[t*FIELDS+2][0];
        eq            = test_mem[t*FIELDS+3][0];
        gt            = test_mem[t*FIELDS+4][0];
        instr_ack     = 1'b1;
        release_delay = int'($urandom % 8);  // Memory may hold ack well past the request
        clear_counts();
    endtask

    // Instruction memory and pulse collection, all on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            collect_pulses();
            if (instr_req && !req_prev) begin
                if (started) begin
                    check_instruction(test_idx);  // Next fetch closes the window
                    test_idx++;
                end
                if (test_idx == n_tests)
                    done = 1'b1;
                ack_delay = int'($urandom % 4);
            end
            if (instr_req && !instr_ack && !done) begin
                if (ack_delay == 0) begin
                    if (!started) begin
                        check_reset();
                        started = 1'b1;
                    end
                    present_instruction(test_idx);
                end else begin
                    ack_delay--;
                end
            end else if (!instr_req && instr_ack) begin
                if (release_delay == 0)
                    instr_ack = 1'b0;
                else
                    release_delay--;
            end
            req_prev = instr_req;
        end
    end

    initial begin
        void'($urandom(52388));
        clk           = 1'b0;
        reset         = 1'b1;
        instr_ack     = 1'b0;
        opcode        = '0;
        funct         = '0;
        ov            = 1'b0;
        eq            = 1'b0;
        gt            = 1'b0;
        started       = 1'b0;
        done          = 1'b0;
        req_prev      = 1'b0;
        test_idx      = 0;
        ack_delay     = 0;
        release_delay = 0;
        errors        = 0;
        checks        = 0;
        clear_counts();
        $readmemh("control_tests.txt", test_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && test_mem[n_tests*FIELDS] !== 8'hff) begin
            n_tests++;
        end
        if (n_tests == 0) begin
            $display("No test lines found in control_tests.txt");
            errors++;
            done = 1'b1;
        end
        cycle_limit = 20*n_tests + 50;
        repeat (4) begin
            @(negedge clk);
            expect_quiet_outputs();
        end
        reset  = 1'b0;
        cycles = 0;
        while (!done && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout after %0d cycles with %0d of %0d tests done",
                     cycles, test_idx, n_tests);
            errors++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* control_tests.txt */
// opcode funct ov eq gt | reg_write mem_wr pc_write epc_write counts | reg_dst mem_to_reg pc_src
// All hex; a line starting with ff ends the list
00 20 0 0 0  1 0 1 0  1 0 0  // add
00 22 0 0 0  1 0 1 0  1 0 0  // sub
00 24 0 0 0  1 0 1 0  1 0 0  // and
08 00 0 0 0  1 0 1 0  0 0 0  // addi
09 00 0 0 0  1 0 1 0  0 0 0  // addiu
0f 00 0 0 0  1 0 1 0  0 8 0  // lui
00 20 1 0 0  0 0 2 1  0 0 3  // add overflow
00 22 1 0 0  0 0 2 1  0 0 3  // sub overflow
08 00 1 0 0  0 0 2 1  0 0 3  // addi overflow
09 00 1 0 0  1 0 1 0  0 0 0  // addiu ignores ov
23 00 0 0 0  1 0 1 0  0 1 0  // lw
2b 00 0 0 0  0 1 1 0  0 0 0  // sw
04 00 0 1 0  0 0 2 0  0 0 1  // beq taken
04 00 0 0 1  0 0 1 0  0 0 0  // beq not taken
05 00 0 0 0  0 0 2 0  0 0 1  // bne taken
05 00 0 1 0  0 0 1 0  0 0 0  // bne not taken
06 00 0 1 0  0 0 2 0  0 0 1  // ble taken
06 00 0 0 1  0 0 1 0  0 0 0  // ble not taken
07 00 0 0 1  0 0 2 0  0 0 1  // bgt taken
07 00 0 1 0  0 0 1 0  0 0 0  // bgt not taken
02 00 0 0 0  0 0 2 0  0 0 2  // j
00 08 0 0 0  0 0 2 0  0 0 0  // jr
03 00 0 0 0  1 0 2 0  3 0 2  // jal
3f 00 0 0 0  0 0 2 1  0 0 3  // undefined opcode
01 00 0 0 0  0 0 2 1  0 0 3  // undefined opcode
00 2a 0 0 0  0 0 2 1  0 0 3  // undefined funct
ff

/* src.f */
cu_pkg.sv
decode_if.sv
instr_decoder.sv
step_sequencer.sv
control_encoder.sv
control_unit.sv
control_unit_asserts.sv
tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; exit status follows the testbench result
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_control_unit \
    -o sim_control_unit && \
./obj_dir/sim_control_unit | tee /dev/stderr | grep -q "Finished with no errors" && \
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
